//--- Bender.yml
package:
  name: trace_subsystem

sources:
  - include_dirs:
      - include
    files:
      - hw/trace_pkg.sv
      - hw/irq_arbiter.sv
      - hw/cobs_framer.sv
      - hw/byte_fifo.sv
      - hw/uart_tx.sv
      - hw/trace_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/trace_props.sv
      - testbench/trace_tb.sv

//--- build.f
+incdir+include
hw/trace_pkg.sv
hw/irq_arbiter.sv
hw/cobs_framer.sv
hw/byte_fifo.sv
hw/uart_tx.sv
hw/trace_top.sv
testbench/trace_props.sv
testbench/trace_tb.sv

//--- hw/byte_fifo.sv
// synchronous byte fifo between framer and uart, circular buffer with occupancy count
`timescale 1ns/1ps
`include "trace_params.svh"

module byte_fifo (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  trace_pkg::byte_t push_data_i,
  input  logic             pop_i,
  output trace_pkg::byte_t pop_data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int depth = `TRACE_FIFO_DEPTH;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  trace_pkg::byte_t mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + ptr_w'(1);
  endfunction

  assign full_o  = count == cnt_w'(depth);
  assign empty_o = count == '0;
  assign wr_en   = push_i && !full_o;
  assign rd_en   = pop_i && !empty_o;

  // head is read straight from the array
  assign pop_data_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // push and pop together leave the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/cobs_framer.sv
// cobs framer that turns one trace event into a five byte frame pushed into the byte fifo
`timescale 1ns/1ps
`include "trace_params.svh"

module cobs_framer (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    ev_valid_i,
  input  trace_pkg::trace_event_t ev_data_i,
  input  logic                    full_i,
  output logic                    busy_o,
  output logic                    push_o,
  output trace_pkg::byte_t        push_data_o
);

  localparam int frame_len = `TRACE_FRAME_LEN;
  // code byte plus payload, everything except the delimiter
  localparam int code_len  = frame_len - 1;
  localparam int idx_w     = $clog2(code_len);

  trace_pkg::framer_state_t          state;
  trace_pkg::byte_t [code_len-2:0]   payload;
  trace_pkg::byte_t [code_len-1:0]   enc_next;
  trace_pkg::byte_t [code_len-1:0]   enc_q;
  logic             [idx_w-1:0]      idx;

  // payload order on the wire is id, stamp high, stamp low
  assign payload[0] = ev_data_i.id;
  assign payload[1] = ev_data_i.stamp[`TRACE_STAMP_WIDTH-1 -: 8];
  assign payload[2] = ev_data_i.stamp[7:0];

  // cobs encode, walking back from the delimiter
  // each zero becomes the distance to the next zero or to the delimiter
  always_comb begin
    int next_zero;
    next_zero = code_len;
    for (int q = code_len - 1; q >= 1; q--) begin
      if (payload[q-1] == '0) begin
        enc_next[q] = trace_pkg::byte_t'(next_zero - q);
        next_zero   = q;
      end else begin
        enc_next[q] = payload[q-1];
      end
    end
    // leading code byte points at the first zero
    enc_next[0] = trace_pkg::byte_t'(next_zero);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= trace_pkg::FRM_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        trace_pkg::FRM_IDLE: begin
          if (ev_valid_i) begin
            state <= trace_pkg::FRM_EMIT;
            idx   <= '0;
          end
        end
        trace_pkg::FRM_EMIT: begin
          // stall in place while the fifo is full
          if (!full_i) begin
            if (idx == idx_w'(code_len - 1)) begin
              state <= trace_pkg::FRM_DELIM;
            end
            idx <= idx + idx_w'(1);
          end
        end
        trace_pkg::FRM_DELIM: begin
          if (!full_i) begin
            state <= trace_pkg::FRM_IDLE;
          end
        end
        default: begin
          state <= trace_pkg::FRM_IDLE;
        end
      endcase
    end
  end

  // encoded bytes captured with the event
  always_ff @(posedge clk_i) begin
    if (state == trace_pkg::FRM_IDLE && ev_valid_i) begin
      enc_q <= enc_next;
    end
  end

  assign busy_o      = state != trace_pkg::FRM_IDLE;
  assign push_o      = (state != trace_pkg::FRM_IDLE) && !full_i;
  assign push_data_o = (state == trace_pkg::FRM_DELIM) ? '0 : enc_q[idx];

endmodule

//--- hw/irq_arbiter.sv
// interrupt arbiter that syncs buttons, latches edges and stamps the highest pending source
`timescale 1ns/1ps
`include "trace_params.svh"

module irq_arbiter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  trace_pkg::src_vec_t     btn_i,
  input  logic                    frm_busy_i,
  output logic                    ev_valid_o,
  output trace_pkg::trace_event_t ev_data_o,
  output trace_pkg::src_vec_t     led_o
);

  trace_pkg::src_vec_t btn_meta;
  trace_pkg::src_vec_t btn_sync;
  trace_pkg::src_vec_t btn_last;
  trace_pkg::src_vec_t btn_rise;
  trace_pkg::src_vec_t pending;
  trace_pkg::src_vec_t grant_vec;
  trace_pkg::src_id_t  grant_id;
  trace_pkg::stamp_t   stamp_cnt;
  logic                grant;

  // two flops against metastability, then the edge register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      btn_meta <= '0;
      btn_sync <= '0;
      btn_last <= '0;
    end else begin
      btn_meta <= btn_i;
      btn_sync <= btn_meta;
      btn_last <= btn_sync;
    end
  end

  assign btn_rise = btn_sync & ~btn_last;

  // higher index wins
  always_comb begin
    grant_id = '0;
    for (int i = 0; i < `TRACE_NUM_SRC; i++) begin
      if (pending[i]) begin
        grant_id = trace_pkg::src_id_t'(i);
      end
    end
  end

  assign grant_vec = trace_pkg::src_vec_t'(1) << grant_id;

  // the strobe cycle itself is blocked since the framer only shows busy one cycle later
  assign grant = !frm_busy_i && !ev_valid_o && (pending != '0);

  // a repeat edge on a pending source just merges
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~(grant_vec & {`TRACE_NUM_SRC{grant}})) | btn_rise;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stamp_cnt  <= '0;
      ev_valid_o <= 1'b0;
      led_o      <= '0;
    end else begin
      stamp_cnt  <= stamp_cnt + trace_pkg::stamp_t'(1);
      ev_valid_o <= grant;
      if (grant) begin
        led_o <= grant_vec;
      end
    end
  end

  // event payload, only meaningful alongside the strobe
  always_ff @(posedge clk_i) begin
    if (grant) begin
      ev_data_o.id    <= grant_id;
      ev_data_o.stamp <= stamp_cnt;
    end
  end

endmodule

//--- hw/trace_pkg.sv
// trace package with the shared vector types, event record and fsm encodings
`include "trace_params.svh"

package trace_pkg;

  // source index as sent in the frame
  typedef logic [7:0] src_id_t;

  // monotonic timer value
  typedef logic [`TRACE_STAMP_WIDTH-1:0] stamp_t;

  // one byte on the wire
  typedef logic [7:0] byte_t;

  // one bit per source, used for buttons, pending and leds
  typedef logic [`TRACE_NUM_SRC-1:0] src_vec_t;

  // event handed from arbiter to framer
  typedef struct packed {
    src_id_t id;
    stamp_t  stamp;
  } trace_event_t;

  // framer fsm
  typedef enum logic [1:0] {
    FRM_IDLE,
    FRM_EMIT,
    FRM_DELIM
  } framer_state_t;

  // uart transmitter fsm
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_t;

endpackage

//--- hw/trace_top.sv
// board top for the event trace path from buttons through arbiter, framer and fifo to uart
`timescale 1ns/1ps

module trace_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  trace_pkg::src_vec_t btn_i,
  output trace_pkg::src_vec_t led_o,
  output logic                tx_o
);

  // arbiter to framer
  logic                    ev_valid;
  trace_pkg::trace_event_t ev_data;
  logic                    frm_busy;

  irq_arbiter arbiter_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .btn_i      (btn_i),
    .frm_busy_i (frm_busy),
    .ev_valid_o (ev_valid),
    .ev_data_o  (ev_data),
    .led_o      (led_o)
  );

  // framer to fifo
  logic             push;
  trace_pkg::byte_t push_data;
  logic             full;

  cobs_framer framer_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ev_valid_i  (ev_valid),
    .ev_data_i   (ev_data),
    .full_i      (full),
    .busy_o      (frm_busy),
    .push_o      (push),
    .push_data_o (push_data)
  );

  // fifo to uart
  logic             pop;
  trace_pkg::byte_t pop_data;
  logic             empty;

  byte_fifo fifo_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .full_o      (full),
    .empty_o     (empty)
  );

  uart_tx uart_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .empty_i (empty),
    .data_i  (pop_data),
    .pop_o   (pop),
    .tx_o    (tx_o)
  );

endmodule

//--- hw/uart_tx.sv
// 8n1 uart transmitter that pulls bytes from the fifo whenever it goes idle
`timescale 1ns/1ps
`include "trace_params.svh"

module uart_tx (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             empty_i,
  input  trace_pkg::byte_t data_i,
  output logic             pop_o,
  output logic             tx_o
);

  localparam int bit_div = `TRACE_BIT_DIV;
  localparam int div_w   = (bit_div > 1) ? $clog2(bit_div) : 1;

  trace_pkg::uart_state_t state;
  trace_pkg::byte_t       shift;
  logic [div_w-1:0]       div_cnt;
  logic [2:0]             bit_cnt;
  logic                   bit_end;

  // last cycle of the current bit period
  assign bit_end = div_cnt == div_w'(bit_div - 1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state   <= trace_pkg::UART_IDLE;
      pop_o   <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      if (state == trace_pkg::UART_IDLE || bit_end) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + div_w'(1);
      end
      case (state)
        trace_pkg::UART_IDLE: begin
          // pop is a single cycle, the head is taken while it is high
          if (pop_o) begin
            pop_o <= 1'b0;
            state <= trace_pkg::UART_START;
          end else if (!empty_i) begin
            pop_o <= 1'b1;
          end
        end
        trace_pkg::UART_START: begin
          if (bit_end) begin
            state   <= trace_pkg::UART_DATA;
            bit_cnt <= '0;
          end
        end
        trace_pkg::UART_DATA: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              state <= trace_pkg::UART_STOP;
            end
            bit_cnt <= bit_cnt + 3'd1;
          end
        end
        trace_pkg::UART_STOP: begin
          if (bit_end) begin
            state <= trace_pkg::UART_IDLE;
          end
        end
        default: begin
          state <= trace_pkg::UART_IDLE;
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk_i) begin
    if (state == trace_pkg::UART_IDLE && pop_o) begin
      shift <= data_i;
    end else if (state == trace_pkg::UART_DATA && bit_end) begin
      shift <= shift >> 1;
    end
  end

  always_comb begin
    case (state)
      trace_pkg::UART_START: tx_o = 1'b0;
      trace_pkg::UART_DATA:  tx_o = shift[0];
      default:               tx_o = 1'b1;
    endcase
  end

endmodule

//--- include/trace_params.svh
// trace subsystem parameters for source count, timer width, fifo depth and uart timing
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// one source per board button
`define TRACE_NUM_SRC 4

// free-running timestamp width
`define TRACE_STAMP_WIDTH 16

// byte fifo entries between framer and uart
`define TRACE_FIFO_DEPTH 16

// clock cycles per uart bit
`define TRACE_BIT_DIV 8

// code byte, id, stamp high, stamp low, delimiter
`define TRACE_FRAME_LEN 5

`endif

//--- testbench/trace_props.sv
// trace protocol checks on the fifo strobes, framer busy timing and uart idle line
`timescale 1ns/1ps

module trace_props (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic                     push_i,
  input logic                     full_i,
  input logic                     pop_i,
  input logic                     empty_i,
  input logic                     ev_valid_i,
  input logic                     frm_busy_i,
  input trace_pkg::framer_state_t frm_state_i,
  input trace_pkg::uart_state_t   uart_state_i,
  input logic                     tx_i
);

  // count of failed assertions
  int failures = 0;

  no_push_when_full: assert property (
    @(posedge clk_i) disable iff (reset_i) !(push_i && full_i)
  ) else begin
    $error("framer pushed while the fifo was full");
    failures++;
  end

  no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (reset_i) !(pop_i && empty_i)
  ) else begin
    $error("uart popped while the fifo was empty");
    failures++;
  end

  // line rests high between bytes
  tx_high_when_idle: assert property (
    @(posedge clk_i) disable iff (reset_i) (uart_state_i == trace_pkg::UART_IDLE) |-> tx_i
  ) else begin
    $error("tx line low while the uart was idle");
    failures++;
  end

  busy_drops_after_delim: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (push_i && frm_state_i == trace_pkg::FRM_DELIM) |=> !frm_busy_i
  ) else begin
    $error("framer still busy one cycle after the delimiter push");
    failures++;
  end

  busy_drops_only_after_delim: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $fell(frm_busy_i) |-> $past(push_i && frm_state_i == trace_pkg::FRM_DELIM)
  ) else begin
    $error("framer busy fell without a delimiter push before it");
    failures++;
  end

  // strobe only toward an idle framer
  event_only_when_idle: assert property (
    @(posedge clk_i) disable iff (reset_i) ev_valid_i |-> !frm_busy_i
  ) else begin
    $error("event strobed while the framer was busy");
    failures++;
  end

endmodule

//--- testbench/trace_tb.sv
// trace subsystem testbench, drives button presses and decodes the cobs frames off the uart line
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_tb;

  localparam int num_src         = `TRACE_NUM_SRC;
  localparam int frame_cycles    = `TRACE_FRAME_LEN * 10 * `TRACE_BIT_DIV;
  localparam int stamp_runs      = 8;
  localparam int max_gap         = 300;
  // single presses, stamp runs, two same-cycle patterns and the burst
  localparam int max_frames      = num_src + stamp_runs + 4 * num_src;
  localparam int watchdog_cycles = max_frames * frame_cycles
                                   + stamp_runs * (max_gap + 280) + 4 * frame_cycles + 2000;

  logic                clk;
  logic                reset;
  trace_pkg::src_vec_t btn;
  trace_pkg::src_vec_t led;
  logic                tx;

  int                  errors = 0;
  int                  frames_rx = 0;
  int                  frames_expected = 0;
  string               test_name = "none";
  int                  exp_q[$];
  trace_pkg::byte_t    rx_bytes[$];
  trace_pkg::stamp_t   last_stamp;
  logic                have_stamp = 1'b0;
  // next frame should carry a zero stamp low byte
  logic                expect_low_zero = 1'b0;

  trace_top dut_i (
    .clk_i   (clk),
    .reset_i (reset),
    .btn_i   (btn),
    .led_o   (led),
    .tx_o    (tx)
  );

  bind trace_top trace_props props_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (push),
    .full_i       (full),
    .pop_i        (pop),
    .empty_i      (empty),
    .ev_valid_i   (ev_valid),
    .frm_busy_i   (frm_busy),
    .frm_state_i  (framer_i.state),
    .uart_state_i (uart_i.state),
    .tx_i         (tx_o)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_id(input int id);
    exp_q.push_back(id);
    frames_expected++;
  endtask

  // called on a falling edge, returns on one
  task automatic press_buttons(input trace_pkg::src_vec_t pat);
    btn = pat;
    repeat (4) @(negedge clk);
    btn = '0;
    repeat (4) @(negedge clk);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // samples near the middle of each bit
  task automatic receive_byte(output trace_pkg::byte_t data);
    data = '0;
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);
    repeat (`TRACE_BIT_DIV / 2) @(negedge clk);
    assert (tx === 1'b0) else begin
      $display("%s: start bit did not hold low", test_name);
      errors++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (`TRACE_BIT_DIV) @(negedge clk);
      data[i] = tx;
    end
    repeat (`TRACE_BIT_DIV) @(negedge clk);
    assert (tx === 1'b1) else begin
      $display("%s: stop bit was low", test_name);
      errors++;
    end
  endtask

  task automatic check_frame();
    trace_pkg::byte_t  body[$];
    trace_pkg::byte_t  data[$];
    trace_pkg::stamp_t stamp;
    trace_pkg::stamp_t delta;
    int                pos;
    int                code;
    body = rx_bytes;
    void'(body.pop_back());
    frames_rx++;
    check_value("frame length", `TRACE_FRAME_LEN, rx_bytes.size());
    // each code byte counts itself plus the data bytes up to the next zero
    pos = 0;
    while (pos < body.size()) begin
      code = body[pos];
      assert (code != 0) else begin
        $display("%s: zero byte inside a frame body", test_name);
        errors++;
      end
      pos++;
      for (int j = 1; j < code && pos < body.size(); j++) begin
        data.push_back(body[pos]);
        pos++;
      end
      if (code < 255 && pos < body.size()) begin
        data.push_back(8'h00);
      end
    end
    check_value("payload length", 3, data.size());
    if (data.size() != 3) return;
    assert (exp_q.size() != 0) else begin
      $display("%s: frame for id %0d arrived with no event expected", test_name, data[0]);
      errors++;
    end
    if (exp_q.size() != 0) begin
      check_value("source id", exp_q.pop_front(), data[0]);
    end
    stamp = {data[1], data[2]};
    delta = stamp - last_stamp;
    // forward by less than half the range counts as later, wrap included
    assert (!have_stamp || (delta != 0 && delta < (1 << (`TRACE_STAMP_WIDTH - 1)))) else begin
      $display("%s: stamp %0h does not follow %0h", test_name, stamp, last_stamp);
      errors++;
    end
    last_stamp = stamp;
    have_stamp = 1'b1;
    if (expect_low_zero) begin
      check_value("stamp low byte", 0, data[2]);
      expect_low_zero = 1'b0;
    end
  endtask

  initial begin : rx_proc
    trace_pkg::byte_t b;
    wait (reset === 1'b0);
    forever begin
      receive_byte(b);
      rx_bytes.push_back(b);
      if (b == 8'h00) begin
        check_frame();
        rx_bytes.delete();
      end
    end
  end

  initial begin : main_proc
    trace_pkg::src_vec_t pat;
    int                  src;
    int                  gap;
    int                  lowest;
    int                  dup;
    void'($urandom(32'h025d_208e));
    btn   = '0;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_name = "reset_idle";
    repeat (20) begin
      @(negedge clk);
      check_value("tx", 1, tx);
      check_value("led", 0, led);
    end

    test_name = "single_press";
    for (int s = 0; s < num_src; s++) begin
      expect_id(s);
      press_buttons(trace_pkg::src_vec_t'(1) << s);
      wait_drained();
      check_value("led", 1 << s, led);
    end

    test_name = "stamp_order";
    for (int k = 0; k < stamp_runs; k++) begin
      src = $urandom % num_src;
      gap = $urandom % (max_gap + 1);
      repeat (gap) @(negedge clk);
      if (k % 2 == 1) begin
        // stamp is taken three cycles after the press, so this lands the low byte on zero
        while (dut_i.arbiter_i.stamp_cnt[7:0] != 8'hfd) @(negedge clk);
        expect_low_zero = 1'b1;
      end
      expect_id(src);
      press_buttons(trace_pkg::src_vec_t'(1) << src);
      wait_drained();
    end

    test_name = "same_cycle";
    pat = '1;
    for (int r = 0; r < 2; r++) begin
      if (r == 1) begin
        pat = '0;
        while ($countones(pat) < 2) pat = trace_pkg::src_vec_t'($urandom);
      end
      lowest = 0;
      for (int i = num_src - 1; i >= 0; i--) begin
        if (pat[i]) begin
          expect_id(i);
          lowest = i;
        end
      end
      press_buttons(pat);
      wait_drained();
      check_value("led", 1 << lowest, led);
    end

    test_name = "fifo_burst";
    pat = '0;
    while (pat == '0) pat = trace_pkg::src_vec_t'($urandom);
    dup = $urandom % num_src;
    while (!pat[dup]) dup = $urandom % num_src;
    for (int i = num_src - 1; i >= 0; i--) expect_id(i);
    for (int i = num_src - 1; i >= 0; i--) begin
      if (pat[i]) expect_id(i);
    end
    press_buttons('1);
    // last frame of the first burst now sits on a full fifo for several byte times
    repeat (52) @(negedge clk);
    for (int i = 0; i < num_src; i++) begin
      if (pat[i]) begin
        press_buttons(trace_pkg::src_vec_t'(1) << i);
        if (i == dup) press_buttons(trace_pkg::src_vec_t'(1) << i);
      end
    end
    wait_drained();

    test_name = "quiet_tail";
    repeat (2 * frame_cycles) @(negedge clk);
    check_value("frame count", frames_expected, frames_rx);

    $display("checks failed: %0d, assertion failures: %0d", errors, dut_i.props_i.failures);
    if (errors == 0 && dut_i.props_i.failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog_proc
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
